//--- logic/memPkg.sv
`default_nettype none

package memPkg;

  // RAM geometry, 1024 words of one byte
  localparam int ADDR_WIDTH = 10;
  localparam int DATA_WIDTH = 8;
  localparam int MEM_DEPTH = 1 << ADDR_WIDTH;

  // cycles that oeN must stay low at a stable address before data is good
  localparam int ACCESS_CYCLES = 3;
  // length of the weN low pulse
  localparam int WRITE_PULSE_CYCLES = 2;

  // wide enough for both the write pulse and the access wait
  localparam int CNT_WIDTH = $clog2(ACCESS_CYCLES + WRITE_PULSE_CYCLES);

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [CNT_WIDTH-1:0] cnt_t;

  // one access at a time, Done holds ack until the host lets go of req
  typedef enum logic [2:0] {
    Idle,
    Setup,
    WritePulse,
    ReadWait,
    Done
  } seqState_e;

endpackage

`default_nettype wire

//--- logic/sramBus_if.sv
`timescale 1ns/100ps
`default_nettype none

// the RAM pins, with read and write data split instead of one tristate bus
interface sramBus_if import memPkg::*; ();

  addr_t addr;
  data_t wrData;
  data_t rdData;
  // active low enables, as on the 6116 and 62256
  logic  weN;
  logic  oeN;
  // high when the addressed word has never been written
  logic  undef;

  modport sequencer (
    output addr,
    output weN,
    output oeN
  );

  modport dataPort (
    output wrData,
    input  rdData,
    input  undef
  );

  modport array (
    input  addr,
    input  wrData,
    input  weN,
    input  oeN,
    output rdData,
    output undef
  );

endinterface

`default_nettype wire

//--- logic/sramSequencer.sv
`timescale 1ns/100ps
`default_nettype none

module sramSequencer import memPkg::*; (
  input  wire         _OE,
  input  wire         rst,
  input  wire         req,
  input  wire         wr,
  input  addr_t       addr,
  output logic        ack,
  output logic        loadWr,
  output logic        captureRd,
  sramBus_if.sequencer bus
);

  seqState_e state;
  cnt_t      cycleCnt;
  addr_t     addrReg;
  logic      isWrite;

  // last counter value of each timed phase
  localparam cnt_t WriteLast = cnt_t'(WRITE_PULSE_CYCLES - 1);
  localparam cnt_t ReadLast = cnt_t'(ACCESS_CYCLES - 1);

  always_ff @(posedge _OE) begin
    if (rst) begin
      state    <= Idle;
      cycleCnt <= '0;
      addrReg  <= '0;
      isWrite  <= 1'b0;
      ack      <= 1'b0;
    end else begin
      // ack trails Done by one cycle, both on the way up and down
      ack <= (state == Done);

      case (state)
        Idle: begin
          if (req) begin
            // address and direction are frozen for the whole access
            addrReg <= addr;
            isWrite <= wr;
            state   <= Setup;
          end
        end

        Setup: begin
          // address has had one cycle to settle before any enable drops
          cycleCnt <= '0;
          if (isWrite) begin
            state <= WritePulse;
          end else begin
            state <= ReadWait;
          end
        end

        WritePulse: begin
          if (cycleCnt == WriteLast) begin
            state <= Done;
          end else begin
            cycleCnt <= cycleCnt + 1'b1;
          end
        end

        ReadWait: begin
          // captureRd fires on the last wait cycle
          if (cycleCnt == ReadLast) begin
            state <= Done;
          end else begin
            cycleCnt <= cycleCnt + 1'b1;
          end
        end

        Done: begin
          // a host that keeps req high simply parks us here
          if (!req) begin
            state <= Idle;
          end
        end

        default: begin
          state <= Idle;
        end
      endcase
    end
  end

  // enables decode straight from the state
  assign bus.addr = addrReg;
  assign bus.weN = (state != WritePulse);
  assign bus.oeN = (state != ReadWait);

  // write word is taken in the same cycle the request is accepted
  assign loadWr = (state == Idle) && req && wr;
  assign captureRd = (state == ReadWait) && (cycleCnt == ReadLast);

  // the RAM must never see both enables low from this controller
  assert property (@(posedge _OE) disable iff (rst)
    !(!bus.weN && !bus.oeN))
    else $error("weN and oeN low together");

  // four-phase rule, ack stays up as long as the host holds req
  assert property (@(posedge _OE) disable iff (rst)
    (ack && req) |=> ack)
    else $error("ack dropped while req still high");

endmodule

`default_nettype wire

//--- logic/dataBusPort.sv
`timescale 1ns/100ps
`default_nettype none

module dataBusPort import memPkg::*; (
  input  wire        _OE,
  input  wire        rst,
  input  data_t      wrData,
  input  wire        loadWr,
  input  wire        captureRd,
  output data_t      rdData,
  output logic       rdUndef,
  sramBus_if.dataPort bus
);

  // host word held on the bus through the whole write pulse
  data_t wrHold;

  always_ff @(posedge _OE) begin
    if (loadWr) begin
      wrHold <= wrData;
    end
  end

  assign bus.wrData = wrHold;

  // read result as the host sees it until the next read
  always_ff @(posedge _OE) begin
    if (rst) begin
      rdData  <= '0;
      rdUndef <= 1'b0;
    end else if (captureRd) begin
      rdData  <= bus.rdData;
      rdUndef <= bus.undef;
    end
  end

endmodule

`default_nettype wire

//--- logic/sramArray.sv
`timescale 1ns/100ps
`default_nettype none

module sramArray import memPkg::*; (
  input  wire      _OE,
  input  wire      rst,
  sramBus_if.array bus
);

  data_t mem [MEM_DEPTH];
  // one flag per word, set by the first write to it
  logic [MEM_DEPTH-1:0] written;

  // read access timing
  addr_t lastAddr;
  cnt_t  accCnt;
  logic  addrSame;
  logic  readValid;

  localparam cnt_t AccLast = cnt_t'(ACCESS_CYCLES - 1);

  // weN low writes whatever oeN does, so write wins
  always_ff @(posedge _OE) begin
    if (!bus.weN) begin
      mem[bus.addr] <= bus.wrData;
    end
  end

  always_ff @(posedge _OE) begin
    if (rst) begin
      written <= '0;
    end else if (!bus.weN) begin
      written[bus.addr] <= 1'b1;
    end
  end

  assign addrSame = (bus.addr == lastAddr);

  // accCnt counts finished cycles of oeN low at the current address
  always_ff @(posedge _OE) begin
    if (rst) begin
      lastAddr <= '0;
      accCnt   <= '0;
    end else begin
      lastAddr <= bus.addr;
      if (bus.oeN) begin
        accCnt <= '0;
      end else if (!addrSame) begin
        // new address, this cycle is the first of its access
        accCnt <= cnt_t'(1);
      end else if (accCnt != AccLast) begin
        accCnt <= accCnt + 1'b1;
      end
    end
  end

  // data is good in the ACCESS_CYCLES-th cycle of a steady read
  assign readValid = !bus.oeN && bus.weN && addrSame && (accCnt == AccLast);

  // never written words read as zero rather than as leftover contents
  assign bus.rdData = (readValid && written[bus.addr]) ? mem[bus.addr] : '0;
  assign bus.undef = !written[bus.addr];

  // the part latches on the rising weN edge, so the address must not move
  assert property (@(posedge _OE) disable iff (rst)
    !bus.weN |=> (bus.weN || $stable(bus.addr)))
    else $error("address changed during a write pulse");

endmodule

`default_nettype wire

//--- logic/memBoard.sv
`timescale 1ns/100ps
`default_nettype none

module memBoard import memPkg::*; (
  input  wire   _OE,
  input  wire   rst,
  input  wire   req,
  output logic  ack,
  input  wire   wr,
  input  addr_t addr,
  input  data_t wrData,
  output data_t rdData,
  output logic  rdUndef
);

  // strobes from the sequencer to the data port
  logic loadWr;
  logic captureRd;

  sramBus_if bus ();

  sramSequencer u_sramSequencer (
    ._OE       (_OE),
    .rst       (rst),
    .req       (req),
    .wr        (wr),
    .addr      (addr),
    .ack       (ack),
    .loadWr    (loadWr),
    .captureRd (captureRd),
    .bus       (bus.sequencer)
  );

  dataBusPort u_dataBusPort (
    ._OE       (_OE),
    .rst       (rst),
    .wrData    (wrData),
    .loadWr    (loadWr),
    .captureRd (captureRd),
    .rdData    (rdData),
    .rdUndef   (rdUndef),
    .bus       (bus.dataPort)
  );

  sramArray u_sramArray (
    ._OE (_OE),
    .rst (rst),
    .bus (bus.array)
  );

endmodule

`default_nettype wire

//--- test/memBoardTests.svh
// directed tests that memBoardTb runs in order

task automatic testWriteRead();
  addr_t a;
  a = 10'h123;
  doWrite(a, 8'h3C);
  checkRead(a, 8'h3C, 1'b0);
  // overwrite of the same word
  doWrite(a, 8'hC3);
  checkRead(a, 8'hC3, 1'b0);
endtask

task automatic testUnwrittenRead();
  checkRead(10'h2F0, 8'h00, 1'b1);
  checkRead(10'h3FE, 8'h00, 1'b1);
endtask

// small address window so reads often hit written words
task automatic testRandomTraffic();
  logic  isWrite;
  addr_t a;
  data_t d;
  for (int n = 0; n < RANDOM_OPS; n++) begin
    isWrite = 1'($urandom % 2);
    a = addr_t'($urandom % 64);
    d = data_t'($urandom);
    if (isWrite) begin
      doWrite(a, d);
    end else begin
      checkAgainstRef(a);
    end
  end
endtask

task automatic testResetClearsFlags();
  addr_t a;
  a = 10'h200;
  doWrite(a, 8'h77);
  checkRead(a, 8'h77, 1'b0);
  applyReset();
  checkRead(a, 8'h00, 1'b1);
  // words from the random traffic lost their flags too
  for (int i = 0; i < 64; i++) begin
    checkAgainstRef(addr_t'(i));
  end
endtask

task automatic testHandshakeHold();
  addr_t a;
  a = 10'h155;
  startAccess(1'b1, a, 8'h96);
  waitAck(1'b1, "ack on the held write");
  // a second access would store this new word
  wrData = 8'h69;
  repeat (10) begin
    @(posedge _OE);
    #2;
    checkValue("ack", 32'(ack), 32'd1);
  end
  endAccess();
  refMem[a] = 8'h96;
  refWritten[a] = 1'b1;
  checkRead(a, 8'h96, 1'b0);
endtask

task automatic testBoundaries();
  data_t pats [4];
  pats = '{8'h00, 8'hFF, 8'hA5, 8'h5A};
  for (int i = 0; i < 4; i++) begin
    doWrite(10'h000, pats[i]);
    // top word untouched by the write at the bottom
    checkAgainstRef(10'h3FF);
    doWrite(10'h3FF, pats[3-i]);
    checkRead(10'h000, pats[i], 1'b0);
    checkRead(10'h3FF, pats[3-i], 1'b0);
  end
endtask

//--- test/memBoardTb.sv
`timescale 1ns/100ps
`default_nettype none

module memBoardTb import memPkg::*; ();

  // cycles allowed for any single ack edge to show up
  localparam int ACK_TIMEOUT = 20;
  localparam int RANDOM_OPS = 200;

  logic  _OE;
  logic  rst;
  logic  req;
  logic  ack;
  logic  wr;
  addr_t addr;
  data_t wrData;
  data_t rdData;
  logic  rdUndef;

  // reference model of the RAM words and their written flags
  data_t refMem [MEM_DEPTH];
  logic  refWritten [MEM_DEPTH];

  memBoard u_memBoard (
    ._OE     (_OE),
    .rst     (rst),
    .req     (req),
    .ack     (ack),
    .wr      (wr),
    .addr    (addr),
    .wrData  (wrData),
    .rdData  (rdData),
    .rdUndef (rdUndef)
  );

  // 40 ns clock
  initial begin
    _OE = 1'b0;
    forever begin
      #20 _OE = ~_OE;
    end
  end

  task automatic abortRun(input string reason);
    $display("=== FAIL ===");
    $fatal(1, "%s", reason);
  endtask

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Fail %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      abortRun({"wrong value on ", name});
    end
  endtask

  // rst high over two rising edges, all written flags gone afterwards
  task automatic applyReset();
    @(posedge _OE);
    #2;
    rst = 1'b1;
    req = 1'b0;
    repeat (2) @(posedge _OE);
    #2;
    rst = 1'b0;
    for (int i = 0; i < MEM_DEPTH; i++) begin
      refWritten[i] = 1'b0;
    end
  endtask

  task automatic waitAck(input logic level, input string what);
    int   cycles;
    logic seen;
    cycles = 0;
    seen = 1'b0;
    while (!seen && cycles < ACK_TIMEOUT) begin
      @(posedge _OE);
      #2;
      cycles = cycles + 1;
      if (ack == level) begin
        seen = 1'b1;
      end
    end
    if (!seen) begin
      abortRun({"timed out waiting for ", what});
    end
  endtask

  task automatic startAccess(input logic isWrite, input addr_t a, input data_t d);
    @(posedge _OE);
    #2;
    wr = isWrite;
    addr = a;
    wrData = d;
    req = 1'b1;
  endtask

  // second half of the handshake
  task automatic endAccess();
    req = 1'b0;
    waitAck(1'b0, "ack to fall after req dropped");
  endtask

  task automatic doWrite(input addr_t a, input data_t d);
    startAccess(1'b1, a, d);
    waitAck(1'b1, "ack after a write");
    endAccess();
    refMem[a] = d;
    refWritten[a] = 1'b1;
  endtask

  task automatic doRead(input addr_t a, output data_t got, output logic undef);
    startAccess(1'b0, a, data_t'(0));
    waitAck(1'b1, "ack after a read");
    // result is only defined while ack is high
    got = rdData;
    undef = rdUndef;
    endAccess();
  endtask

  task automatic checkRead(input addr_t a, input data_t expData, input logic expUndef);
    data_t got;
    logic  undef;
    doRead(a, got, undef);
    checkValue("rdData", 32'(got), 32'(expData));
    checkValue("rdUndef", 32'(undef), 32'(expUndef));
  endtask

  // a never written word comes back as zero with the flag set
  task automatic checkAgainstRef(input addr_t a);
    data_t expData;
    expData = refWritten[a] ? refMem[a] : data_t'(0);
    checkRead(a, expData, !refWritten[a]);
  endtask

`include "memBoardTests.svh"

  initial begin
    void'($urandom(32'h2fa16209));
    rst = 1'b1;
    req = 1'b0;
    wr = 1'b0;
    addr = '0;
    wrData = '0;
    applyReset();
    checkValue("ack", 32'(ack), 32'd0);
    checkValue("rdData", 32'(rdData), 32'd0);
    testWriteRead();
    testUnwrittenRead();
    testRandomTraffic();
    testResetClearsFlags();
    testHandshakeHold();
    testBoundaries();
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
+incdir+test
logic/memPkg.sv
logic/sramBus_if.sv
logic/sramSequencer.sv
logic/dataBusPort.sv
logic/sramArray.sv
logic/memBoard.sv
test/memBoardTb.sv

//--- Makefile
# Verilator build and run for the SRAM memory board

VERILATOR ?= verilator
FILELIST  ?= all.f
TOP       ?= memBoardTb
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
SIM_ARGS  ?=

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(wildcard logic/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# the exit status of the simulation is the result of the run
run: build
	./$(SIM_BIN) $(SIM_ARGS)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
